// File: dv/sgd_tb.sv
// directed tests of sgd_top with default parameters; stops at the first error
// expected values come from a reference model of dot product, gradient and update
`timescale 1ns/1ps

module sgd_tb;

    localparam int NB      = sgd_layout_pkg::DEFAULT_NUM_BANKS;
    localparam int NF      = sgd_layout_pkg::DEFAULT_NUM_FEATURES;
    localparam int PW      = NB * NF;
    localparam int AW      = (NF > 1) ? $clog2(NF) : 1;
    localparam int TIMEOUT = 500;

    logic clk;
    logic reset;
    logic [sgd_layout_pkg::BITS_WIDTH-1:0] number_of_bits;
    logic a_wr_en;
    logic [PW-1:0] a_data;
    logic a_almost_full;
    logic dot_valid;
    sgd_types_pkg::weight_t [NB-1:0] dot_product;
    logic loss_valid;
    sgd_types_pkg::weight_t [NB-1:0] loss;
    logic [AW-1:0] x_rd_addr;
    sgd_types_pkg::weight_t x_rd_data;

    // reference model state
    logic [31:0] ref_w [NF];
    logic [31:0] loss_vec [NB];
    logic [PW-1:0] planes [sgd_layout_pkg::MAX_BITS];
    int batch_bits;
    int error_count;
    integer seed;

    sgd_top dut0 (
        .clk(clk), .reset(reset), .number_of_bits(number_of_bits),
        .a_wr_en(a_wr_en), .a_data(a_data), .a_almost_full(a_almost_full),
        .dot_valid(dot_valid), .dot_product(dot_product),
        .loss_valid(loss_valid), .loss(loss),
        .x_rd_addr(x_rd_addr), .x_rd_data(x_rd_data)
    );

    // 40 ns period
    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checking and waiting
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "first mismatch, simulation stopped");
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("TIMEOUT at %0t: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "wait timed out, simulation stopped");
    endtask

    // all waits leave us 1 ns after a rising edge
    task automatic wait_input_ready();
        int cycles;
        cycles = 0;
        while (a_almost_full)
        begin
            if (cycles >= TIMEOUT)
                report_timeout("a_almost_full stayed high, input never freed");
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // batch, loss and host read
    //////////////////////////////////////////////////////////////////////

    // random planes, msb first, checked against the shift-and-add model
    // with stray set, a random loss rides along with every plane
    task automatic send_batch(input int nbits, input bit stray);
        logic [31:0] expected;
        batch_bits = nbits;
        for (int i = 0; i < nbits; i++)
            planes[i] = PW'({$random(seed), $random(seed)});
        for (int i = 0; i < nbits; i++)
        begin
            wait_input_ready();
            number_of_bits = sgd_layout_pkg::BITS_WIDTH'(nbits);
            a_wr_en = 1'b1;
            a_data = planes[i];
            if (stray)
            begin
                for (int b = 0; b < NB; b++)
                    loss[b] = $random(seed);
                loss_valid = 1'b1;
            end
            @(posedge clk);
            #1;
            if (i < nbits - 1)
                check_value("dot_valid", 32'd0, 32'(dot_valid));
        end
        a_wr_en = 1'b0;
        loss_valid = 1'b0;
        // pulse lands in the cycle right after the last plane
        check_value("dot_valid", 32'd1, 32'(dot_valid));
        check_value("a_almost_full", 32'd1, 32'(a_almost_full));
        for (int b = 0; b < NB; b++)
        begin
            expected = '0;
            for (int i = 0; i < nbits; i++)
            begin
                expected = expected << 1;
                for (int f = 0; f < NF; f++)
                    if (planes[i][b*NF + f])
                        expected = expected + ref_w[f];
            end
            check_value($sformatf("dot_product[%0d]", b), expected, dot_product[b]);
        end
        @(posedge clk);
        #1;
        check_value("dot_valid", 32'd0, 32'(dot_valid));
    endtask

    // send loss_vec, update the model, wait for the input to reopen
    task automatic apply_loss();
        logic [31:0] grad;
        int cycles;
        check_value("a_almost_full", 32'd1, 32'(a_almost_full));
        for (int b = 0; b < NB; b++)
            loss[b] = loss_vec[b];
        loss_valid = 1'b1;
        @(posedge clk);
        #1;
        loss_valid = 1'b0;
        for (int f = 0; f < NF; f++)
        begin
            grad = '0;
            for (int i = 0; i < batch_bits; i++)
            begin
                grad = grad << 1;
                for (int b = 0; b < NB; b++)
                    if (planes[i][b*NF + f])
                        grad = grad + loss_vec[b];
            end
            ref_w[f] = ref_w[f] - grad;
        end
        cycles = 0;
        while (a_almost_full)
        begin
            if (cycles >= TIMEOUT)
                report_timeout("model update never released a_almost_full");
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic random_losses();
        for (int b = 0; b < NB; b++)
            loss_vec[b] = $random(seed);
    endtask

    // data comes two edges after the address
    task automatic check_all_weights();
        for (int f = 0; f < NF; f++)
        begin
            x_rd_addr = AW'(f);
            @(posedge clk);
            @(posedge clk);
            #1;
            check_value($sformatf("x_rd_data[%0d]", f), ref_w[f], x_rd_data);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        check_value("a_almost_full", 32'd0, 32'(a_almost_full));
        check_value("dot_valid", 32'd0, 32'(dot_valid));
        check_all_weights();
    endtask

    task automatic test_first_update();
        for (int b = 0; b < NB; b++)
            loss_vec[b] = 32'(b + 1);
        // weights are still zero, so every bank must read 0
        send_batch(4, 1'b0);
        apply_loss();
        check_all_weights();
    endtask

    task automatic test_dot_product();
        int lengths [3] = '{1, 8, 16};
        for (int k = 0; k < 3; k++)
        begin
            random_losses();
            send_batch(lengths[k], 1'b0);
            apply_loss();
        end
        check_all_weights();
    endtask

    task automatic test_backpressure();
        send_batch(8, 1'b0);
        random_losses();
        for (int c = 0; c < 50; c++)
        begin
            check_value("a_almost_full", 32'd1, 32'(a_almost_full));
            check_value("dot_valid", 32'd0, 32'(dot_valid));
            // offer a word mid-wait, it must be dropped
            a_wr_en = (c >= 10 && c < 20);
            a_data = PW'({$random(seed), $random(seed)});
            @(posedge clk);
            #1;
        end
        a_wr_en = 1'b0;
        apply_loss();
        // a leaked word would skew this batch
        random_losses();
        send_batch(5, 1'b0);
        apply_loss();
        check_all_weights();
    endtask

    task automatic test_stray_loss();
        check_value("a_almost_full", 32'd0, 32'(a_almost_full));
        // idle with an empty fifo
        for (int c = 0; c < 5; c++)
        begin
            for (int b = 0; b < NB; b++)
                loss[b] = $random(seed);
            loss_valid = 1'b1;
            @(posedge clk);
            #1;
        end
        loss_valid = 1'b0;
        check_all_weights();
        // stray losses while planes already sit in the fifo
        random_losses();
        send_batch(6, 1'b1);
        apply_loss();
        check_all_weights();
    endtask

    task automatic test_random_run();
        int nbits;
        for (int n = 0; n < 20; n++)
        begin
            nbits = 1 + ($unsigned($random(seed)) % sgd_layout_pkg::MAX_BITS);
            random_losses();
            send_batch(nbits, 1'b0);
            apply_loss();
        end
        check_all_weights();
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        number_of_bits = '0;
        a_wr_en = 1'b0;
        a_data = '0;
        loss_valid = 1'b0;
        loss = '0;
        x_rd_addr = '0;
        error_count = 0;
        seed = 62;
        batch_bits = 0;
        for (int f = 0; f < NF; f++)
            ref_w[f] = '0;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_first_update();
        test_dot_product();
        test_backpressure();
        test_stray_loss();
        test_random_run();

        if (error_count == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/sgd_layout_pkg.sv
source/sgd_types_pkg.sv
source/plane_if.sv
source/dot_product_unit.sv
source/sample_fifo.sv
source/gradient_unit.sv
source/model_store.sv
source/sgd_top.sv
dv/sgd_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the sgd testbench with Verilator, runs it into sim.log, then scans the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module sgd_tb -o sgd_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/sgd_sim > sim.log 2>&1

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"

// File: source/dot_product_unit.sv
// number_of_bits above MAX_BITS is clamped; 0 is not a legal batch length
`timescale 1ns/1ps

module dot_product_unit #(
    parameter int NUM_BANKS    = sgd_layout_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_FEATURES = sgd_layout_pkg::DEFAULT_NUM_FEATURES
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic [sgd_layout_pkg::BITS_WIDTH-1:0]      number_of_bits,
    input  logic                                       a_wr_en,
    input  logic [NUM_BANKS*NUM_FEATURES-1:0]          a_data,
    output logic                                       a_almost_full,
    input  sgd_types_pkg::weight_t [NUM_FEATURES-1:0]  weights,
    input  logic                                       upd_valid,
    output logic                                       dot_valid,
    output sgd_types_pkg::weight_t [NUM_BANKS-1:0]     dot_product,
    plane_if.source                                    plane_out
);

    localparam int BW = sgd_layout_pkg::BITS_WIDTH;
    localparam logic [BW-1:0] MAX_BITS_V = BW'(sgd_layout_pkg::MAX_BITS);

    sgd_types_pkg::dot_state_t state;
    logic [BW-1:0] bits_r;
    logic [BW-1:0] plane_cnt;
    logic [BW-1:0] batch_bits;
    logic [BW-1:0] plane_idx;
    logic accept;
    logic first;
    logic is_last;
    sgd_types_pkg::weight_t [NUM_BANKS-1:0] acc;
    sgd_types_pkg::weight_t [NUM_BANKS-1:0] acc_next;

    // hold off the host while waiting for the loss, or if the fifo ever fills
    assign a_almost_full = (state == sgd_types_pkg::DOT_WAIT_UPDATE) || !plane_out.ready;
    assign accept = a_wr_en && !a_almost_full;

    // batch length is latched at the first plane
    assign first = (state == sgd_types_pkg::DOT_IDLE);
    assign batch_bits = !first ? bits_r :
                        (number_of_bits > MAX_BITS_V) ? MAX_BITS_V : number_of_bits;
    assign plane_idx = first ? '0 : plane_cnt;
    assign is_last = (plane_idx == batch_bits - 1'b1);

    // every accepted plane goes straight into the fifo
    assign plane_out.valid = accept;
    assign plane_out.data  = a_data;
    assign plane_out.last  = is_last;

    // shift-and-add, msb plane first so each step doubles
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            acc_next[b] = first ? '0 : (acc[b] <<< 1);
            for (int f = 0; f < NUM_FEATURES; f++)
            begin
                if (a_data[b*NUM_FEATURES + f])
                begin
                    acc_next[b] = acc_next[b] + weights[f];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // batch FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= sgd_types_pkg::DOT_IDLE;
            bits_r    <= '0;
            plane_cnt <= '0;
            dot_valid <= 1'b0;
        end
        else
        begin
            // one-cycle pulse after the last plane
            dot_valid <= accept && is_last;
            case (state)
                sgd_types_pkg::DOT_IDLE, sgd_types_pkg::DOT_ACCUM:
                begin
                    if (accept)
                    begin
                        bits_r    <= batch_bits;
                        plane_cnt <= plane_idx + 1'b1;
                        state     <= is_last ? sgd_types_pkg::DOT_WAIT_UPDATE
                                             : sgd_types_pkg::DOT_ACCUM;
                    end
                end
                sgd_types_pkg::DOT_WAIT_UPDATE:
                begin
                    // model is fresh again on the next cycle
                    if (upd_valid)
                    begin
                        state <= sgd_types_pkg::DOT_IDLE;
                    end
                end
                default:
                begin
                    state <= sgd_types_pkg::DOT_IDLE;
                end
            endcase
        end
    end

    // accumulators and output registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            acc <= acc_next;
            if (is_last)
            begin
                dot_product <= acc_next;
            end
        end
    end

endmodule

// File: source/gradient_unit.sv
// loss must already carry the step size; gradient wraps mod 2^32
`timescale 1ns/1ps

module gradient_unit #(
    parameter int NUM_BANKS    = sgd_layout_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_FEATURES = sgd_layout_pkg::DEFAULT_NUM_FEATURES
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       loss_valid,
    input  sgd_types_pkg::weight_t [NUM_BANKS-1:0]     loss,
    plane_if.sink                                      plane_in,
    output logic                                       upd_valid,
    output sgd_types_pkg::weight_t [NUM_FEATURES-1:0]  upd_grad
);

    sgd_types_pkg::grad_state_t state;
    sgd_types_pkg::weight_t [NUM_BANKS-1:0]    loss_r;
    sgd_types_pkg::weight_t [NUM_FEATURES-1:0] grad;
    sgd_types_pkg::weight_t [NUM_FEATURES-1:0] grad_next;
    logic start;
    logic pop;

    // a loss only makes sense with a batch sitting in the fifo
    assign start = (state == sgd_types_pkg::GRAD_IDLE) && loss_valid && plane_in.valid;

    // drain one plane per cycle while replaying
    assign plane_in.ready = (state == sgd_types_pkg::GRAD_ACCUM);
    assign pop = plane_in.valid && plane_in.ready;

    assign upd_valid = (state == sgd_types_pkg::GRAD_APPLY);
    assign upd_grad  = grad;

    // per feature, double then add losses of banks with the bit set
    always_comb
    begin
        for (int f = 0; f < NUM_FEATURES; f++)
        begin
            grad_next[f] = grad[f] <<< 1;
            for (int b = 0; b < NUM_BANKS; b++)
            begin
                if (plane_in.data[b*NUM_FEATURES + f])
                begin
                    grad_next[f] = grad_next[f] + loss_r[b];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // replay FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= sgd_types_pkg::GRAD_IDLE;
        end
        else
        begin
            case (state)
                sgd_types_pkg::GRAD_IDLE:
                begin
                    if (start)
                    begin
                        state <= sgd_types_pkg::GRAD_ACCUM;
                    end
                end
                sgd_types_pkg::GRAD_ACCUM:
                begin
                    if (pop && plane_in.last)
                    begin
                        state <= sgd_types_pkg::GRAD_APPLY;
                    end
                end
                // single update cycle
                default:
                begin
                    state <= sgd_types_pkg::GRAD_IDLE;
                end
            endcase
        end
    end

    // loss latch and gradient accumulators
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            loss_r <= loss;
            grad   <= '0;
        end
        else if (pop)
        begin
            grad <= grad_next;
        end
    end

endmodule

// File: source/model_store.sv
// host read has two cycles of latency; addresses past NUM_FEATURES read as 0
`timescale 1ns/1ps

module model_store #(
    parameter int NUM_FEATURES = sgd_layout_pkg::DEFAULT_NUM_FEATURES,
    localparam int ADDR_WIDTH  = (NUM_FEATURES > 1) ? $clog2(NUM_FEATURES) : 1
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       upd_valid,
    input  sgd_types_pkg::weight_t [NUM_FEATURES-1:0]  upd_grad,
    output sgd_types_pkg::weight_t [NUM_FEATURES-1:0]  weights,
    input  logic [ADDR_WIDTH-1:0]                      x_rd_addr,
    output sgd_types_pkg::weight_t                     x_rd_data
);

    logic [ADDR_WIDTH-1:0] addr_r;

    // model registers, one gradient step per update pulse
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            weights <= '0;
        end
        else if (upd_valid)
        begin
            for (int f = 0; f < NUM_FEATURES; f++)
            begin
                weights[f] <= weights[f] - upd_grad[f];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // host read, address stage then data stage
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        addr_r    <= x_rd_addr;
        x_rd_data <= (addr_r < NUM_FEATURES) ? weights[addr_r] : '0;
    end

endmodule

// File: source/plane_if.sv
// valid/ready stream of bit planes; source holds data and last while stalled
`timescale 1ns/1ps

interface plane_if #(
    parameter int NUM_BANKS    = sgd_layout_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_FEATURES = sgd_layout_pkg::DEFAULT_NUM_FEATURES
);
    // bit (bank * NUM_FEATURES + feature) of one plane
    logic [NUM_BANKS*NUM_FEATURES-1:0] data;
    logic valid;
    // final plane of a batch
    logic last;
    logic ready;

    // producer side
    modport source (output valid, output data, output last, input ready);

    // consumer side
    modport sink (input valid, input data, input last, output ready);

endinterface

// File: source/sample_fifo.sv
// register-array fifo with fall-through read; depth 2**FIFO_DEPTH_BITS
`timescale 1ns/1ps

module sample_fifo #(
    parameter int NUM_BANKS       = sgd_layout_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_FEATURES    = sgd_layout_pkg::DEFAULT_NUM_FEATURES,
    parameter int FIFO_DEPTH_BITS = sgd_layout_pkg::DEFAULT_FIFO_DEPTH_BITS
) (
    input  logic   clk,
    input  logic   reset,
    plane_if.sink  wr,
    plane_if.source rd
);

    localparam int PLANE_WIDTH = NUM_BANKS * NUM_FEATURES;
    localparam int DEPTH       = 2 ** FIFO_DEPTH_BITS;

    // storage, plane plus its last flag
    logic [PLANE_WIDTH-1:0] mem_data [DEPTH];
    logic                   mem_last [DEPTH];

    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_DEPTH_BITS:0]   count;
    logic push;
    logic pop;

    // count msb is set only when all DEPTH entries are used
    assign wr.ready = !count[FIFO_DEPTH_BITS];
    assign rd.valid = (count != '0);
    assign rd.data  = mem_data[rd_ptr];
    assign rd.last  = mem_last[rd_ptr];

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/sgd_layout_pkg.sv
// layout constants of the bit-plane stream and defaults of the top-level parameters
// planes are one bit per feature per sample, most significant plane first
package sgd_layout_pkg;

    //////////////////////////////////////////////////////////////////////
    // arithmetic widths
    //////////////////////////////////////////////////////////////////////

    // weights, dot products, losses and gradients, all wrap mod 2^32
    localparam int WEIGHT_WIDTH = 32;

    // longest batch in planes, and width of the plane counters
    localparam int MAX_BITS   = 16;
    localparam int BITS_WIDTH = 5;

    //////////////////////////////////////////////////////////////////////
    // defaults for sgd_top
    //////////////////////////////////////////////////////////////////////
    localparam int DEFAULT_NUM_BANKS    = 8;
    localparam int DEFAULT_NUM_FEATURES = 8;
    // 32 entries, must stay >= MAX_BITS
    localparam int DEFAULT_FIFO_DEPTH_BITS = 5;

endpackage

// File: source/sgd_top.sv
// one batch in flight at a time; number_of_bits must not change inside a batch
// loss is only taken while a_almost_full is high after dot_valid
`timescale 1ns/1ps

module sgd_top #(
    parameter int NUM_BANKS       = sgd_layout_pkg::DEFAULT_NUM_BANKS,
    parameter int NUM_FEATURES    = sgd_layout_pkg::DEFAULT_NUM_FEATURES,
    parameter int FIFO_DEPTH_BITS = sgd_layout_pkg::DEFAULT_FIFO_DEPTH_BITS,
    localparam int ADDR_WIDTH     = (NUM_FEATURES > 1) ? $clog2(NUM_FEATURES) : 1
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [sgd_layout_pkg::BITS_WIDTH-1:0]    number_of_bits,
    // input side
    input  logic                                     a_wr_en,
    input  logic [NUM_BANKS*NUM_FEATURES-1:0]        a_data,
    output logic                                     a_almost_full,
    // dot products out
    output logic                                     dot_valid,
    output sgd_types_pkg::weight_t [NUM_BANKS-1:0]   dot_product,
    // losses back in
    input  logic                                     loss_valid,
    input  sgd_types_pkg::weight_t [NUM_BANKS-1:0]   loss,
    // host read of the model
    input  logic [ADDR_WIDTH-1:0]                    x_rd_addr,
    output sgd_types_pkg::weight_t                   x_rd_data
);

    // model path
    sgd_types_pkg::weight_t [NUM_FEATURES-1:0] weights;
    sgd_types_pkg::weight_t [NUM_FEATURES-1:0] upd_grad;
    logic upd_valid;
    logic loss_window_valid;

    plane_if #(.NUM_BANKS(NUM_BANKS), .NUM_FEATURES(NUM_FEATURES)) plane_wr ();
    plane_if #(.NUM_BANKS(NUM_BANKS), .NUM_FEATURES(NUM_FEATURES)) plane_rd ();

    // stray losses outside the wait window are dropped here
    assign loss_window_valid = loss_valid && a_almost_full;

    dot_product_unit #(.NUM_BANKS(NUM_BANKS), .NUM_FEATURES(NUM_FEATURES)) dot_unit0 (
        .clk(clk), .reset(reset), .number_of_bits(number_of_bits),
        .a_wr_en(a_wr_en), .a_data(a_data), .a_almost_full(a_almost_full),
        .weights(weights), .upd_valid(upd_valid),
        .dot_valid(dot_valid), .dot_product(dot_product), .plane_out(plane_wr)
    );

    sample_fifo #(
        .NUM_BANKS(NUM_BANKS), .NUM_FEATURES(NUM_FEATURES), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
    ) fifo0 (.clk(clk), .reset(reset), .wr(plane_wr), .rd(plane_rd));

    gradient_unit #(.NUM_BANKS(NUM_BANKS), .NUM_FEATURES(NUM_FEATURES)) grad_unit0 (
        .clk(clk), .reset(reset), .loss_valid(loss_window_valid), .loss(loss),
        .plane_in(plane_rd), .upd_valid(upd_valid), .upd_grad(upd_grad)
    );

    model_store #(.NUM_FEATURES(NUM_FEATURES)) model0 (
        .clk(clk), .reset(reset), .upd_valid(upd_valid), .upd_grad(upd_grad),
        .weights(weights), .x_rd_addr(x_rd_addr), .x_rd_data(x_rd_data)
    );

endmodule

// File: source/sgd_types_pkg.sv
// value types and FSM state encodings of the SGD engine
// weight_t is two's complement, no saturation anywhere
package sgd_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // values
    //////////////////////////////////////////////////////////////////////

    // one weight, dot product, loss or gradient
    typedef logic signed [sgd_layout_pkg::WEIGHT_WIDTH-1:0] weight_t;

    //////////////////////////////////////////////////////////////////////
    // states
    //////////////////////////////////////////////////////////////////////

    // input side: idle, inside a batch, waiting for the model update
    typedef enum logic [1:0] {
        DOT_IDLE,
        DOT_ACCUM,
        DOT_WAIT_UPDATE
    } dot_state_t;

    // gradient side: waiting for a loss, replaying planes, one-cycle update
    typedef enum logic [1:0] {
        GRAD_IDLE,
        GRAD_ACCUM,
        GRAD_APPLY
    } grad_state_t;

endpackage
